//--- Makefile
# Verilator build and run of the core_block testbench

VERILATOR ?= verilator
TOP       ?= core_block_tb
FILELIST  ?= core_block.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

# Sources come from the file list, option lines skipped
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- core_block.f
src/core_block_pkg.sv
src/status_regs.sv
src/bc_msg_encoder.sv
src/bc_msg_fifo.sv
src/dmem_bank.sv
src/core_block.sv
dv/core_block_assert.sv
dv/core_block_tb.sv

//--- dv/core_block_assert.sv
`timescale 1ns/1ns

module core_block_assert (
  input logic                    clk,
  input logic                    core_rst,
  input logic                    msg_push,
  input logic                    fifo_full,
  input core_block_pkg::bc_msg_t bc_msg_out,
  input logic                    bc_msg_out_valid,
  input logic                    bc_msg_out_ready,
  input logic                    core_mem_en,
  input logic                    core_mem_wen,
  input logic                    core_mem_ready,
  input logic                    core_mem_rd_valid
);

  logic rd_acc;

  // Accepted read on the core port
  assign rd_acc = core_mem_en && core_mem_ready && !core_mem_wen;

  ////////////////////////////////////////////////////////////
  // Message buffer
  ////////////////////////////////////////////////////////////

  push_not_full: assert property (
    @(posedge clk) disable iff (core_rst) !(msg_push && fifo_full)
  ) else $error("Message pushed into a full FIFO");

  // Stalled message holds its value
  out_stable: assert property (
    @(posedge clk) disable iff (core_rst)
    (bc_msg_out_valid && !bc_msg_out_ready) |=> (bc_msg_out_valid && $stable(bc_msg_out))
  ) else $error("bc_msg_out changed while stalled");

  ////////////////////////////////////////////////////////////
  // Read latency
  ////////////////////////////////////////////////////////////

  rd_valid_after_read: assert property (
    @(posedge clk) disable iff (core_rst) rd_acc |=> core_mem_rd_valid
  ) else $error("core_mem_rd_valid missing one cycle after a read");

  rd_valid_only_after_read: assert property (
    @(posedge clk) disable iff (core_rst) core_mem_rd_valid |-> $past(rd_acc)
  ) else $error("core_mem_rd_valid without a read one cycle before");

endmodule

bind core_block core_block_assert core_block_assert_i (
  .clk               (clk),
  .core_rst          (core_rst),
  .msg_push          (msg_push),
  .fifo_full         (fifo_full),
  .bc_msg_out        (bc_msg_out),
  .bc_msg_out_valid  (bc_msg_out_valid),
  .bc_msg_out_ready  (bc_msg_out_ready),
  .core_mem_en       (core_mem_en),
  .core_mem_wen      (core_mem_wen),
  .core_mem_ready    (core_mem_ready),
  .core_mem_rd_valid (core_mem_rd_valid)
);

//--- dv/core_block_tb.sv
`timescale 1ns/1ns

module core_block_tb;

  import core_block_pkg::*;

  localparam int DMEM_WORDS = 1024;
  localparam int FIFO_DEPTH = 4;
  localparam int ADDR_W     = $clog2(DMEM_WORDS);
  localparam int OFF_W      = $bits(bc_off_t);
  localparam int CLK_PERIOD = 8;
  localparam int WAIT_LIMIT = 64;
  // Cycle estimate of each test in the order they run
  localparam int TEST_CYCLES = 20 + 20 + 80 + 80 + 50 + 70;
  localparam int TIMEOUT_NS  = (2 * TEST_CYCLES + 100) * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic              clk;
  logic              core_rst;
  logic              core_mem_en;
  logic              core_mem_wen;
  strb_t             core_mem_strb;
  logic [ADDR_W-1:0] core_mem_addr;
  word_t             core_mem_wr_data;
  logic              core_mem_ready;
  word_t             core_mem_rd_data;
  logic              core_mem_rd_valid;
  bc_msg_t           bc_msg_in;
  logic              bc_msg_in_valid;
  bc_msg_t           bc_msg_out;
  logic              bc_msg_out_valid;
  logic              bc_msg_out_ready;
  word_t             wrapper_status_data;
  status_addr_t      wrapper_status_addr;
  logic              wrapper_status_valid;
  logic              wrapper_status_ready;
  word_t             core_status_data;
  status_addr_t      core_status_addr;
  logic              core_status_valid;
  logic              core_status_ready;
  logic              slot_wr_valid;
  word_t             slot_wr_data;
  logic              slot_wr_ready;
  logic [63:0]       debug_out;
  logic              debug_out_l_valid;
  logic              debug_out_h_valid;
  logic [7:0]        core_errors;
  logic              ready_to_evict;
  block_cfg_t        cfg;

  // Reference state
  logic [31:0] lfsr_state;
  word_t       mem_model [DMEM_WORDS];
  bc_msg_t     exp_msgs [$];

  core_block #(
    .DMEM_WORDS (DMEM_WORDS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) core_block_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  function automatic logic [ADDR_W-1:0] region_addr(input bc_off_t off);
    return {{(ADDR_W - OFF_W){1'b1}}, off};
  endfunction

  function automatic void apply_bytes(input logic [ADDR_W-1:0] addr, input strb_t strb,
                                      input word_t data);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        mem_model[addr][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic fail_run();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [127:0] got,
                          input logic [127:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic init_inputs();
    clk                  = 1'b0;
    core_rst             = 1'b1;
    core_mem_en          = 1'b0;
    core_mem_wen         = 1'b0;
    core_mem_strb        = '0;
    core_mem_addr        = '0;
    core_mem_wr_data     = '0;
    bc_msg_in            = '0;
    bc_msg_in_valid      = 1'b0;
    bc_msg_out_ready     = 1'b1;
    wrapper_status_data  = '0;
    wrapper_status_addr  = '0;
    wrapper_status_valid = 1'b0;
    core_status_ready    = 1'b1;
    slot_wr_valid        = 1'b0;
    slot_wr_data         = '0;
    debug_out            = '0;
    debug_out_l_valid    = 1'b0;
    debug_out_h_valid    = 1'b0;
    core_errors          = '0;
    ready_to_evict       = 1'b0;
    lfsr_state           = 32'd98;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    core_rst <= 1'b1;
    repeat (2) @(posedge clk);
    core_rst <= 1'b0;
  endtask

  // One core access, waits for ready, checks read data
  task automatic mem_op(input logic wen, input strb_t strb, input logic [ADDR_W-1:0] addr,
                        input word_t data);
    int waited;
    waited = 0;
    @(posedge clk);
    core_mem_en      <= 1'b1;
    core_mem_wen     <= wen;
    core_mem_strb    <= strb;
    core_mem_addr    <= addr;
    core_mem_wr_data <= data;
    @(negedge clk);
    while (!core_mem_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Core memory request was never accepted, core_mem_ready stayed low");
        fail_run();
      end
      @(negedge clk);
    end
    // Accepted at the coming edge
    if (wen) begin
      apply_bytes(addr, strb, data);
      if (&addr[ADDR_W-1:OFF_W]) begin
        exp_msgs.push_back({addr[OFF_W-1:0], strb, data});
      end
    end
    @(posedge clk);
    core_mem_en <= 1'b0;
    if (!wen) begin
      @(negedge clk);
      check_eq("core_mem_rd_valid", core_mem_rd_valid, 1);
      check_eq("core_mem_rd_data", core_mem_rd_data, mem_model[addr]);
    end
  endtask

  task automatic write_status(input status_addr_t addr, input word_t data);
    @(posedge clk);
    wrapper_status_valid <= 1'b1;
    wrapper_status_addr  <= addr;
    wrapper_status_data  <= data;
    @(posedge clk);
    wrapper_status_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_msgs.size() != 0 || bc_msg_out_valid) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Broadcast messages did not all leave on bc_msg_out");
        fail_run();
      end
      @(negedge clk);
    end
  endtask

  // Every message that leaves must be the oldest expected one
  always @(negedge clk) begin
    if (!core_rst && bc_msg_out_valid && bc_msg_out_ready) begin
      if (exp_msgs.size() == 0) begin
        $display("A message left on bc_msg_out when none was expected");
        fail_run();
      end else begin
        check_eq("bc_msg_out", bc_msg_out, exp_msgs.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_status_regs();
    block_cfg_t exp;
    word_t      w;
    exp = '0;
    for (int a = 0; a < 4; a++) begin
      w = rand_bits(32);
      write_status(status_addr_t'(a), w);
      case (a)
        0: begin
          exp.bc_region_size = w[15:0];
          exp.max_slot_count = w[23:16];
          exp.core_id        = w[31:24];
        end
        1: exp.active_slots    = w;
        2: exp.debug_in[31:0]  = w;
        default: exp.debug_in[63:32] = w;
      endcase
      @(negedge clk);
      check_eq("cfg", cfg, exp);
      check_eq("wrapper_status_ready", wrapper_status_ready, 1);
    end
    apply_reset();
    @(negedge clk);
    check_eq("cfg", cfg, 0);
    check_eq("core_mem_ready", core_mem_ready, 1);
    check_eq("bc_msg_out_valid", bc_msg_out_valid, 0);
    check_eq("core_mem_rd_valid", core_mem_rd_valid, 0);
  endtask

  task automatic test_status_priority();
    status_addr_t exp_addr;
    word_t        exp_data;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      slot_wr_valid     <= i[0];
      debug_out_l_valid <= i[1];
      debug_out_h_valid <= i[2];
      core_status_ready <= i[3];
      slot_wr_data      <= rand_bits(32);
      debug_out         <= {rand_bits(32), rand_bits(32)};
      core_errors       <= 8'(rand_bits(8));
      ready_to_evict    <= rand_bits(1) != 0;
      @(negedge clk);
      if (slot_wr_valid) begin
        exp_addr = 2'd1;
        exp_data = slot_wr_data;
      end else if (debug_out_l_valid) begin
        exp_addr = 2'd2;
        exp_data = debug_out[31:0];
      end else if (debug_out_h_valid) begin
        exp_addr = 2'd3;
        exp_data = debug_out[63:32];
      end else begin
        exp_addr = 2'd0;
        exp_data = {14'd0, 1'b0, ready_to_evict, 7'd0, 1'b0, core_errors};
      end
      check_eq("core_status_addr", core_status_addr, exp_addr);
      check_eq("core_status_data", core_status_data, exp_data);
      check_eq("core_status_valid", core_status_valid, 1);
      check_eq("slot_wr_ready", slot_wr_ready, core_status_ready);
    end
    @(posedge clk);
    slot_wr_valid     <= 1'b0;
    debug_out_l_valid <= 1'b0;
    debug_out_h_valid <= 1'b0;
    core_status_ready <= 1'b1;
  endtask

  task automatic test_memory();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      // Below the broadcast region
      addr = {1'b0, (ADDR_W-1)'(rand_bits(ADDR_W - 1))};
      mem_op(1'b1, 4'hF, addr, rand_bits(32));
      mem_op(1'b1, strb_t'(rand_bits(4)), addr, rand_bits(32));
      mem_op(1'b0, 4'h0, addr, '0);
      check_eq("bc_msg_out_valid", bc_msg_out_valid, 0);
    end
  endtask

  task automatic test_bc_out();
    bc_off_t off;
    for (int i = 0; i < 6; i++) begin
      off = bc_off_t'(rand_bits(OFF_W));
      mem_op(1'b1, 4'hF, region_addr(off), rand_bits(32));
      mem_op(1'b1, strb_t'(rand_bits(4)), region_addr(off), rand_bits(32));
      mem_op(1'b0, 4'h0, region_addr(off), '0);
    end
    wait_drain();
  endtask

  task automatic test_backpressure();
    @(posedge clk);
    bc_msg_out_ready <= 1'b0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      mem_op(1'b1, 4'hF, region_addr(bc_off_t'(rand_bits(OFF_W))), rand_bits(32));
    end
    @(negedge clk);
    check_eq("core_mem_ready", core_mem_ready, 0);
    check_eq("core_status_addr", core_status_addr, 0);
    check_eq("core_status_data[8]", core_status_data[8], 1);
    // One more store stalls until the network takes messages
    fork
      mem_op(1'b1, 4'hF, region_addr(bc_off_t'(rand_bits(OFF_W))), rand_bits(32));
      begin
        repeat (4) @(posedge clk);
        bc_msg_out_ready <= 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic test_bc_in();
    bc_msg_t msg;
    bc_off_t off;
    word_t   core_data;
    for (int i = 0; i < 4; i++) begin
      off = bc_off_t'(rand_bits(OFF_W));
      mem_op(1'b1, 4'hF, region_addr(off), rand_bits(32));
      msg = {off, strb_t'(rand_bits(4)), rand_bits(32)};
      @(posedge clk);
      bc_msg_in       <= msg;
      bc_msg_in_valid <= 1'b1;
      @(posedge clk);
      bc_msg_in_valid <= 1'b0;
      apply_bytes(region_addr(off), msg.strb, msg.data);
      mem_op(1'b0, 4'h0, region_addr(off), '0);
    end
    // Core store and incoming message on the same word
    off       = bc_off_t'(rand_bits(OFF_W));
    core_data = rand_bits(32);
    msg       = {off, 4'b0110, rand_bits(32)};
    @(posedge clk);
    core_mem_en      <= 1'b1;
    core_mem_wen     <= 1'b1;
    core_mem_strb    <= 4'hF;
    core_mem_addr    <= region_addr(off);
    core_mem_wr_data <= core_data;
    bc_msg_in        <= msg;
    bc_msg_in_valid  <= 1'b1;
    @(negedge clk);
    check_eq("core_mem_ready", core_mem_ready, 1);
    apply_bytes(region_addr(off), 4'hF, core_data);
    apply_bytes(region_addr(off), msg.strb, msg.data);
    exp_msgs.push_back({off, 4'hF, core_data});
    @(posedge clk);
    core_mem_en     <= 1'b0;
    bc_msg_in_valid <= 1'b0;
    mem_op(1'b0, 4'h0, region_addr(off), '0);
    wait_drain();
  endtask

  initial begin
    init_inputs();
    apply_reset();
    test_status_regs();
    test_status_priority();
    test_memory();
    test_bc_out();
    test_backpressure();
    test_bc_in();
    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished");
    fail_run();
  end

endmodule

//--- src/bc_msg_encoder.sv
`timescale 1ns/1ns

module bc_msg_encoder #(
  parameter int DMEM_WORDS = 1024
) (
  // Core memory request
  input  logic                            core_mem_en,
  input  logic                            core_mem_wen,
  input  core_block_pkg::strb_t           core_mem_strb,
  input  logic [$clog2(DMEM_WORDS)-1:0]   core_mem_addr,
  input  core_block_pkg::word_t           core_mem_wr_data,

  // Message buffer side
  input  logic                            fifo_full,
  output logic                            core_mem_ready,
  output logic                            push,
  output core_block_pkg::bc_msg_t         msg
);

  import core_block_pkg::*;

  localparam int ADDR_W = $clog2(DMEM_WORDS);
  localparam int OFF_W  = $bits(bc_off_t);

  logic in_region;
  logic accepted;

  // A full buffer holds off every access, reads included
  assign core_mem_ready = !fifo_full;
  assign accepted       = core_mem_en && core_mem_ready;

  // Region is the top of DMEM, upper address bits all ones
  assign in_region = &core_mem_addr[ADDR_W-1:OFF_W];

  assign push = accepted && core_mem_wen && in_region;

  // Payload follows the request, push qualifies it
  assign msg.offset = core_mem_addr[OFF_W-1:0];
  assign msg.strb   = core_mem_strb;
  assign msg.data   = core_mem_wr_data;

endmodule

//--- src/bc_msg_fifo.sv
`timescale 1ns/1ns

module bc_msg_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    core_rst,

  input  logic                    push,
  input  core_block_pkg::bc_msg_t push_msg,
  output logic                    full,

  // Toward the broadcast network
  output core_block_pkg::bc_msg_t out_msg,
  output logic                    out_valid,
  input  logic                    out_ready
);

  import core_block_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  bc_msg_t buf_mem [FIFO_DEPTH];

  // Pointers wrap on their own since the depth is a power of two
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;

  assign full      = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_msg   = buf_mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= push_msg;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (core_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/core_block.sv
`timescale 1ns/1ns

module core_block #(
  parameter int DMEM_WORDS = 1024,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          core_rst,

  // Core data memory port
  input  logic                          core_mem_en,
  input  logic                          core_mem_wen,
  input  core_block_pkg::strb_t         core_mem_strb,
  input  logic [$clog2(DMEM_WORDS)-1:0] core_mem_addr,
  input  core_block_pkg::word_t         core_mem_wr_data,
  output logic                          core_mem_ready,
  output core_block_pkg::word_t         core_mem_rd_data,
  output logic                          core_mem_rd_valid,

  // Broadcast messages
  input  core_block_pkg::bc_msg_t       bc_msg_in,
  input  logic                          bc_msg_in_valid,
  output core_block_pkg::bc_msg_t       bc_msg_out,
  output logic                          bc_msg_out_valid,
  input  logic                          bc_msg_out_ready,

  // Wrapper status channel
  input  core_block_pkg::word_t         wrapper_status_data,
  input  core_block_pkg::status_addr_t  wrapper_status_addr,
  input  logic                          wrapper_status_valid,
  output logic                          wrapper_status_ready,

  // Core status channel
  output core_block_pkg::word_t         core_status_data,
  output core_block_pkg::status_addr_t  core_status_addr,
  output logic                          core_status_valid,
  input  logic                          core_status_ready,

  // Status sources from the core
  input  logic                          slot_wr_valid,
  input  core_block_pkg::word_t         slot_wr_data,
  output logic                          slot_wr_ready,
  input  logic [63:0]                   debug_out,
  input  logic                          debug_out_l_valid,
  input  logic                          debug_out_h_valid,
  input  logic [7:0]                    core_errors,
  input  logic                          ready_to_evict,

  output core_block_pkg::block_cfg_t    cfg
);

  import core_block_pkg::*;

  logic    fifo_full;
  logic    msg_push;
  bc_msg_t msg_enc;
  logic    core_mem_acc;

  // Accepted request toward the memory
  assign core_mem_acc = core_mem_en && core_mem_ready;

  ////////////////////////////////////////////////////////////
  // Status channels
  ////////////////////////////////////////////////////////////

  status_regs status_regs_i (
    .clk                  (clk),
    .core_rst             (core_rst),
    .wrapper_status_valid (wrapper_status_valid),
    .wrapper_status_addr  (wrapper_status_addr),
    .wrapper_status_data  (wrapper_status_data),
    .wrapper_status_ready (wrapper_status_ready),
    .cfg                  (cfg),
    .slot_wr_valid        (slot_wr_valid),
    .slot_wr_data         (slot_wr_data),
    .slot_wr_ready        (slot_wr_ready),
    .debug_out            (debug_out),
    .debug_out_l_valid    (debug_out_l_valid),
    .debug_out_h_valid    (debug_out_h_valid),
    .core_errors          (core_errors),
    .ready_to_evict       (ready_to_evict),
    .fifo_full            (fifo_full),
    .core_status_valid    (core_status_valid),
    .core_status_addr     (core_status_addr),
    .core_status_data     (core_status_data),
    .core_status_ready    (core_status_ready)
  );

  ////////////////////////////////////////////////////////////
  // Broadcast out path
  ////////////////////////////////////////////////////////////

  bc_msg_encoder #(
    .DMEM_WORDS (DMEM_WORDS)
  ) bc_msg_encoder_i (
    .core_mem_en      (core_mem_en),
    .core_mem_wen     (core_mem_wen),
    .core_mem_strb    (core_mem_strb),
    .core_mem_addr    (core_mem_addr),
    .core_mem_wr_data (core_mem_wr_data),
    .fifo_full        (fifo_full),
    .core_mem_ready   (core_mem_ready),
    .push             (msg_push),
    .msg              (msg_enc)
  );

  bc_msg_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) bc_msg_fifo_i (
    .clk       (clk),
    .core_rst  (core_rst),
    .push      (msg_push),
    .push_msg  (msg_enc),
    .full      (fifo_full),
    .out_msg   (bc_msg_out),
    .out_valid (bc_msg_out_valid),
    .out_ready (bc_msg_out_ready)
  );

  ////////////////////////////////////////////////////////////
  // Local data memory
  ////////////////////////////////////////////////////////////

  dmem_bank #(
    .DMEM_WORDS (DMEM_WORDS)
  ) dmem_bank_i (
    .clk           (clk),
    .core_rst      (core_rst),
    .core_en       (core_mem_acc),
    .core_wen      (core_mem_wen),
    .core_strb     (core_mem_strb),
    .core_addr     (core_mem_addr),
    .core_wr_data  (core_mem_wr_data),
    .core_rd_data  (core_mem_rd_data),
    .core_rd_valid (core_mem_rd_valid),
    .bc_in_valid   (bc_msg_in_valid),
    .bc_in_msg     (bc_msg_in)
  );

endmodule

//--- src/core_block_pkg.sv
package core_block_pkg;

  // Data word on the core memory port and the status channels
  typedef logic [31:0] word_t;

  // One enable per byte of a word
  typedef logic [3:0] strb_t;

  // Word offset inside the broadcast region (top 256 words of DMEM)
  typedef logic [7:0] bc_off_t;

  // Status channel address, both directions
  typedef logic [1:0] status_addr_t;

  // Broadcast message, 44 bits
  // Offset sits in the top bits, the same layout as the network side
  typedef struct packed {
    bc_off_t offset;
    strb_t   strb;
    word_t   data;
  } bc_msg_t;

  // Configuration loaded over the wrapper status channel
  typedef struct packed {
    logic [15:0] bc_region_size;
    logic [7:0]  max_slot_count;
    logic [7:0]  core_id;
    logic [31:0] active_slots;
    logic [63:0] debug_in;
  } block_cfg_t;

  // Wrapper status channel addresses
  localparam status_addr_t WR_ADDR_REGION = 2'd0;
  localparam status_addr_t WR_ADDR_SLOTS  = 2'd1;
  localparam status_addr_t WR_ADDR_DBG_L  = 2'd2;
  localparam status_addr_t WR_ADDR_DBG_H  = 2'd3;

  // Core status channel addresses
  localparam status_addr_t CS_ADDR_FLAGS  = 2'd0;
  localparam status_addr_t CS_ADDR_SLOT   = 2'd1;
  localparam status_addr_t CS_ADDR_DBG_L  = 2'd2;
  localparam status_addr_t CS_ADDR_DBG_H  = 2'd3;

endpackage

//--- src/dmem_bank.sv
`timescale 1ns/1ns

module dmem_bank #(
  parameter int DMEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          core_rst,

  // Core port, core_en is an accepted request
  input  logic                          core_en,
  input  logic                          core_wen,
  input  core_block_pkg::strb_t         core_strb,
  input  logic [$clog2(DMEM_WORDS)-1:0] core_addr,
  input  core_block_pkg::word_t         core_wr_data,
  output core_block_pkg::word_t         core_rd_data,
  output logic                          core_rd_valid,

  // Broadcast messages from the network
  input  logic                          bc_in_valid,
  input  core_block_pkg::bc_msg_t       bc_in_msg
);

  import core_block_pkg::*;

  localparam int ADDR_W = $clog2(DMEM_WORDS);
  localparam int OFF_W  = $bits(bc_off_t);
  localparam int NBYTES = $bits(strb_t);

  word_t mem [DMEM_WORDS];

  logic              core_wr;
  logic              core_rd;
  logic [ADDR_W-1:0] bc_addr;

  assign core_wr = core_en && core_wen;
  assign core_rd = core_en && !core_wen;

  // Incoming offset lands in the top region
  assign bc_addr = {{(ADDR_W-OFF_W){1'b1}}, bc_in_msg.offset};

  ////////////////////////////////////////////////////////////
  // Byte writes
  ////////////////////////////////////////////////////////////

  // Broadcast write comes last, so it wins on a shared byte
  always_ff @(posedge clk) begin
    for (int b = 0; b < NBYTES; b++) begin
      if (core_wr && core_strb[b]) begin
        mem[core_addr][8*b +: 8] <= core_wr_data[8*b +: 8];
      end
    end
    for (int b = 0; b < NBYTES; b++) begin
      if (bc_in_valid && bc_in_msg.strb[b]) begin
        mem[bc_addr][8*b +: 8] <= bc_in_msg.data[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered read
  ////////////////////////////////////////////////////////////

  // Old contents if a broadcast write hits the same word this cycle
  always_ff @(posedge clk) begin
    if (core_rd) begin
      core_rd_data <= mem[core_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      core_rd_valid <= 1'b0;
    end else begin
      core_rd_valid <= core_rd;
    end
  end

endmodule

//--- src/status_regs.sv
`timescale 1ns/1ns

module status_regs (
  input  logic                       clk,
  input  logic                       core_rst,

  // Wrapper to core
  input  logic                       wrapper_status_valid,
  input  core_block_pkg::status_addr_t wrapper_status_addr,
  input  core_block_pkg::word_t      wrapper_status_data,
  output logic                       wrapper_status_ready,
  output core_block_pkg::block_cfg_t cfg,

  // Status sources from the core
  input  logic                       slot_wr_valid,
  input  core_block_pkg::word_t      slot_wr_data,
  output logic                       slot_wr_ready,
  input  logic [63:0]                debug_out,
  input  logic                       debug_out_l_valid,
  input  logic                       debug_out_h_valid,
  input  logic [7:0]                 core_errors,
  input  logic                       ready_to_evict,
  input  logic                       fifo_full,

  // Core to wrapper
  output logic                       core_status_valid,
  output core_block_pkg::status_addr_t core_status_addr,
  output core_block_pkg::word_t      core_status_data,
  input  logic                       core_status_ready
);

  import core_block_pkg::*;

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  // Always accepts, one register group per address
  assign wrapper_status_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      cfg <= '0;
    end else if (wrapper_status_valid) begin
      case (wrapper_status_addr)
        WR_ADDR_REGION: begin
          cfg.bc_region_size <= wrapper_status_data[15:0];
          cfg.max_slot_count <= wrapper_status_data[23:16];
          cfg.core_id        <= wrapper_status_data[31:24];
        end
        WR_ADDR_SLOTS: cfg.active_slots    <= wrapper_status_data;
        WR_ADDR_DBG_L: cfg.debug_in[31:0]  <= wrapper_status_data;
        WR_ADDR_DBG_H: cfg.debug_in[63:32] <= wrapper_status_data;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Core status mux
  ////////////////////////////////////////////////////////////

  // Flag word, bit 17 core reset, bit 16 evict, bit 8 FIFO full
  word_t flag_word;

  assign flag_word = {14'd0, core_rst, ready_to_evict, 7'd0, fifo_full, core_errors};

  assign core_status_valid = 1'b1;
  assign slot_wr_ready     = core_status_ready;

  // Slot write first, then debug low, then debug high
  always_comb begin
    if (slot_wr_valid) begin
      core_status_addr = CS_ADDR_SLOT;
      core_status_data = slot_wr_data;
    end else if (debug_out_l_valid) begin
      core_status_addr = CS_ADDR_DBG_L;
      core_status_data = debug_out[31:0];
    end else if (debug_out_h_valid) begin
      core_status_addr = CS_ADDR_DBG_H;
      core_status_data = debug_out[63:32];
    end else begin
      core_status_addr = CS_ADDR_FLAGS;
      core_status_data = flag_word;
    end
  end

endmodule
